// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_store_unit
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := tests failed
PASS_MSG := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dmem.sv ====
`timescale 1ns/1ps

module dmem (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [3:0]                          be,
    input  logic [31:0]                         addr,
    input  logic [31:0]                         wdata,
    input  logic [synth_store_pkg::dmem_aw-1:0] rd_addr,
    output logic [31:0]                         rd_data
);

    logic [31:0]                         mem [synth_store_pkg::dmem_words];
    logic [synth_store_pkg::dmem_aw-1:0] wr_idx;

    assign wr_idx = addr[2 +: synth_store_pkg::dmem_aw];   // word index

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // observation port, one cycle latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= 32'd0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  synth_store_pkg::store_req_t  req,
    output synth_store_pkg::lane_write_t lw
);

    logic [7:0]  rs2_b;
    logic [15:0] rs2_h;

    assign rs2_b = req.wdata[7:0];
    assign rs2_h = req.wdata[15:0];

    always_comb begin
        lw.addr = req.addr;
        lw.be = 4'b0000;
        lw.data = req.wdata;
        if (req.we) begin
            case (req.funct3)
                synth_store_pkg::fnc_sb: begin
                    case (req.addr[1:0])
                        2'b00: begin
                            lw.be = 4'b0001;
                            lw.data = {24'b0, rs2_b};
                        end
                        2'b01: begin
                            lw.be = 4'b0010;
                            lw.data = {16'b0, rs2_b, 8'b0};
                        end
                        2'b10: begin
                            lw.be = 4'b0100;
                            lw.data = {8'b0, rs2_b, 16'b0};
                        end
                        default: begin
                            lw.be = 4'b1000;
                            lw.data = {rs2_b, 24'b0};
                        end
                    endcase
                end
                synth_store_pkg::fnc_sh: begin
                    if (req.addr[1]) begin   // upper half
                        lw.be = 4'b1100;
                        lw.data = {rs2_h, 16'b0};
                    end else begin
                        lw.be = 4'b0011;
                        lw.data = {16'b0, rs2_h};
                    end
                end
                synth_store_pkg::fnc_sw: begin
                    lw.be = 4'b1111;
                    lw.data = req.wdata;
                end
                default: begin
                    lw.be = 4'b0000;   // unknown width, drop it
                    lw.data = req.wdata;
                end
            endcase
        end
    end

endmodule

// ==== store_decode.sv ====
`timescale 1ns/1ps

module store_decode (
    input  synth_store_pkg::lane_write_t lw,
    output logic [3:0]                   dmem_be,
    output synth_store_pkg::reg_sel_t    sel
);

    logic                                    mmio_hit;
    logic                                    dmem_hit;
    logic                                    any_lane;
    logic                                    lane0;
    logic [9:0]                              word_off;
    logic [synth_store_pkg::num_voices-1:0]  voice_win;
    logic                                    voice_low_ok;

    assign mmio_hit = lw.addr[synth_store_pkg::mmio_base_bit];
    assign dmem_hit = lw.addr[synth_store_pkg::dmem_base_bit] && !mmio_hit;
    assign any_lane = |lw.be;
    assign lane0 = lw.be[0];   // narrow fields live in byte 0
    assign word_off = lw.addr[11:2];
    assign voice_win = lw.addr[synth_store_pkg::voice_base_bit +: synth_store_pkg::num_voices];
    assign voice_low_ok = lw.addr[11:5] == 7'd0;

    assign dmem_be = dmem_hit ? lw.be : 4'b0000;

    always_comb begin
        sel = '0;
        if (mmio_hit) begin
            // global registers sit below the voice windows
            if (voice_win == '0) begin
                sel.counter_clr = any_lane &&
                    word_off == synth_store_pkg::off_counter_rst[11:2];
                sel.leds = lane0 &&
                    word_off == synth_store_pkg::off_leds[11:2];
                sel.global_shift = lane0 &&
                    word_off == synth_store_pkg::off_global_shift[11:2];
                for (int w = 0; w < synth_store_pkg::num_waves; w++) begin
                    sel.wave_shift[w] = lane0 &&
                        word_off == synth_store_pkg::off_wave_shift[w][11:2];
                end
            end
            for (int v = 0; v < synth_store_pkg::num_voices; v++) begin
                // exactly one window bit, low bits must be a known offset
                if (voice_win == (synth_store_pkg::num_voices)'(1 << v) && voice_low_ok) begin
                    sel.voice_fcw[v] = any_lane &&
                        lw.addr[4:2] == synth_store_pkg::voff_fcw[4:2];
                    sel.voice_start[v] = any_lane &&
                        lw.addr[4:2] == synth_store_pkg::voff_start[4:2];
                    sel.voice_release[v] = any_lane &&
                        lw.addr[4:2] == synth_store_pkg::voff_release[4:2];
                    sel.voice_reset[v] = any_lane &&
                        lw.addr[4:2] == synth_store_pkg::voff_reset[4:2];
                end
            end
        end
    end

endmodule

// ==== store_unit_assertions.sv ====
`timescale 1ns/1ps

module store_unit_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic [3:0]                  dmem_be,
    input synth_store_pkg::reg_sel_t   sel,
    input synth_store_pkg::synth_cfg_t cfg
);

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel))
        else $error("more than one synth register selected");

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_be != 4'b0000 && sel != '0))
        else $error("memory write and register select active together");

    a_cfg_reset: assert property (@(posedge clk) $rose(rst_n) |-> cfg == '0)
        else $error("cfg not zero after reset release");

    // a pulse with no new store behind it drops after one cycle
    for (genvar v = 0; v < synth_store_pkg::num_voices; v++) begin : g_pulse
        a_start_one: assert property (@(posedge clk) disable iff (!rst_n)
            cfg.note_start[v] && !sel.voice_start[v] |=> !cfg.note_start[v])
            else $error("note start of voice %0d held too long", v);
        a_release_one: assert property (@(posedge clk) disable iff (!rst_n)
            cfg.note_release[v] && !sel.voice_release[v] |=> !cfg.note_release[v])
            else $error("note release of voice %0d held too long", v);
        a_rst_one: assert property (@(posedge clk) disable iff (!rst_n)
            cfg.voice_rst[v] && !sel.voice_reset[v] |=> !cfg.voice_rst[v])
            else $error("voice reset of voice %0d held too long", v);
    end

endmodule

bind store_unit_top store_unit_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .dmem_be (dmem_be),
    .sel     (sel),
    .cfg     (cfg)
);

// ==== store_unit_top.sv ====
`timescale 1ns/1ps

module store_unit_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  synth_store_pkg::store_req_t         req,
    input  logic [synth_store_pkg::dmem_aw-1:0] rd_addr,
    output logic [31:0]                         rd_data,
    output synth_store_pkg::synth_cfg_t         cfg
);

    synth_store_pkg::lane_write_t lw;
    synth_store_pkg::reg_sel_t    sel;
    logic [3:0]                   dmem_be;

    store_align u_align (
        .req (req),
        .lw  (lw)
    );

    store_decode u_decode (
        .lw      (lw),
        .dmem_be (dmem_be),
        .sel     (sel)
    );

    dmem u_dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .be      (dmem_be),
        .addr    (lw.addr),
        .wdata   (lw.data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    synth_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .sel   (sel),
        .lw    (lw),
        .cfg   (cfg)
    );

endmodule

// ==== synth_regs.sv ====
`timescale 1ns/1ps

module synth_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  synth_store_pkg::reg_sel_t    sel,
    input  synth_store_pkg::lane_write_t lw,
    output synth_store_pkg::synth_cfg_t  cfg
);

    logic [synth_store_pkg::shift_w-1:0] shift_in;

    assign shift_in = lw.data[synth_store_pkg::shift_w-1:0];

    // note pulses, high only for the cycle after the store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.note_start <= '0;
            cfg.note_release <= '0;
            cfg.voice_rst <= '0;
        end else begin
            cfg.note_start <= sel.voice_start;
            cfg.note_release <= sel.voice_release;
            cfg.voice_rst <= sel.voice_reset;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.cycle_count <= 32'd0;
        end else if (sel.counter_clr) begin
            cfg.cycle_count <= 32'd0;
        end else begin
            cfg.cycle_count <= cfg.cycle_count + 32'd1;   // free running
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.leds <= 8'd0;
            cfg.global_shift <= '0;
            cfg.wave_shift <= '0;
        end else begin
            if (sel.leds) begin
                cfg.leds <= lw.data[7:0];
            end
            if (sel.global_shift) begin
                cfg.global_shift <= shift_in;
            end
            for (int w = 0; w < synth_store_pkg::num_waves; w++) begin
                if (sel.wave_shift[w]) begin
                    cfg.wave_shift[w] <= shift_in;
                end
            end
        end
    end

    // fcw is 24 bits, so byte lane 3 has nowhere to go
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.fcw <= '0;
        end else begin
            for (int v = 0; v < synth_store_pkg::num_voices; v++) begin
                if (sel.voice_fcw[v]) begin
                    for (int b = 0; b < synth_store_pkg::fcw_w / 8; b++) begin
                        if (lw.be[b]) begin
                            cfg.fcw[v][8*b +: 8] <= lw.data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== synth_store_pkg.sv ====
package synth_store_pkg;

    // RV32 store funct3 codes
    localparam logic [2:0] fnc_sb = 3'b000;
    localparam logic [2:0] fnc_sh = 3'b001;
    localparam logic [2:0] fnc_sw = 3'b010;

    localparam int num_voices = 4;
    localparam int num_waves = 4;     // sine, square, triangle, sawtooth
    localparam int fcw_w = 24;
    localparam int shift_w = 5;

    localparam int dmem_words = 1024;
    localparam int dmem_aw = $clog2(dmem_words);

    // address map
    localparam int dmem_base_bit = 28;
    localparam int mmio_base_bit = 31;
    localparam int voice_base_bit = 12;   // bit 12 + n picks voice n

    localparam logic [11:0] off_counter_rst = 12'h018;
    localparam logic [11:0] off_leds = 12'h030;
    localparam logic [11:0] off_global_shift = 12'h104;
    localparam logic [num_waves-1:0][11:0] off_wave_shift = {
        12'h20c, 12'h208, 12'h204, 12'h200
    };   // index 0 is sine

    // word offsets inside a voice window
    localparam logic [4:0] voff_fcw = 5'h00;
    localparam logic [4:0] voff_start = 5'h04;
    localparam logic [4:0] voff_release = 5'h08;
    localparam logic [4:0] voff_reset = 5'h10;

    typedef struct packed {
        logic        we;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] wdata;   // rs2
    } store_req_t;

    typedef struct packed {
        logic [3:0]  be;
        logic [31:0] data;
        logic [31:0] addr;
    } lane_write_t;

    typedef struct packed {
        logic                  counter_clr;
        logic                  leds;
        logic                  global_shift;
        logic [num_waves-1:0]  wave_shift;
        logic [num_voices-1:0] voice_fcw;
        logic [num_voices-1:0] voice_start;
        logic [num_voices-1:0] voice_release;
        logic [num_voices-1:0] voice_reset;
    } reg_sel_t;

    typedef struct packed {
        logic [num_voices-1:0][fcw_w-1:0]  fcw;
        logic [num_voices-1:0]             note_start;
        logic [num_voices-1:0]             note_release;
        logic [num_voices-1:0]             voice_rst;
        logic [shift_w-1:0]                global_shift;
        logic [num_waves-1:0][shift_w-1:0] wave_shift;
        logic [7:0]                        leds;
        logic [31:0]                       cycle_count;
    } synth_cfg_t;

endpackage

// ==== tb_store_unit.sv ====
`timescale 1ns/1ps

module tb_store_unit;

    localparam int clk_period = 40;
    localparam int reset_cycles = 8;
    localparam int mem_slots = 8;
    localparam int mem_stores = 24;
    localparam int count_cycles = 10;
    localparam logic [31:0] lfsr_seed = 32'h45dfcca3;
    // cycles per test, summed for the watchdog
    localparam int test_cycles = reset_cycles + 1
        + 2 * mem_slots + mem_stores + 1
        + synth_store_pkg::num_voices * 5 + 3
        + synth_store_pkg::num_voices * 3 * 2
        + 12
        + count_cycles + 2;
    localparam int timeout_ns = (test_cycles + 200) * clk_period;

    logic                                clk;
    logic                                rst_n;
    synth_store_pkg::store_req_t         req;
    logic [synth_store_pkg::dmem_aw-1:0] rd_addr;
    logic [31:0]                         rd_data;
    synth_store_pkg::synth_cfg_t         cfg;

    logic [31:0] lfsr_state;
    logic [31:0] mem_model [synth_store_pkg::dmem_words];
    logic [31:0] fcw_model [synth_store_pkg::num_voices];

    store_unit_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .cfg     (cfg)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // expected word after a store of width f3 at byte offset lo
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [2:0] f3,
                                                input logic [1:0] lo, input logic [31:0] rs2);
        logic [31:0] w;
        int          first;
        int          n;
        w = old;
        first = 0;
        n = 0;
        if (f3 == synth_store_pkg::fnc_sb) begin
            n = 1;
            first = int'(lo);
        end else if (f3 == synth_store_pkg::fnc_sh) begin
            n = 2;
            first = lo[1] ? 2 : 0;
        end else if (f3 == synth_store_pkg::fnc_sw) begin
            n = 4;
        end
        for (int i = 0; i < n; i++) begin
            w[8*(first+i) +: 8] = rs2[8*i +: 8];
        end
        return w;
    endfunction

    function automatic logic [31:0] mem_addr(input logic [9:0] idx, input logic [1:0] lo);
        return {20'h10000, idx, lo};
    endfunction

    function automatic logic [31:0] voice_addr(input int v, input logic [11:0] off);
        return 32'h8000_0000 | (32'h0000_1000 << v) | {20'd0, off};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic do_store(input logic [2:0] f3, input logic [31:0] addr,
                            input logic [31:0] data);
        req.we = 1'b1;
        req.funct3 = f3;
        req.addr = addr;
        req.wdata = data;
        @(negedge clk);
        req.we = 1'b0;
    endtask

    task automatic read_word(input logic [9:0] idx, output logic [31:0] data);
        rd_addr = idx;
        @(negedge clk);
        data = rd_data;   // registered read
    endtask

    task automatic check_voices(input string what);
        for (int v = 0; v < synth_store_pkg::num_voices; v++) begin
            check(32'(cfg.fcw[v]), {8'd0, fcw_model[v][23:0]}, what);
        end
        check(32'(cfg.note_start), 32'd0, "note start idle");
        check(32'(cfg.note_release), 32'd0, "note release idle");
        check(32'(cfg.voice_rst), 32'd0, "voice reset idle");
    endtask

    task automatic test_reset();
        check_voices("fcw after reset");
        check(32'(cfg.global_shift), 32'd0, "global shift after reset");
        check(32'(cfg.wave_shift), 32'd0, "wave shift after reset");
        check(32'(cfg.leds), 32'd0, "leds after reset");
        check(cfg.cycle_count, 32'd0, "cycle count after reset");
    endtask

    task automatic test_mem_lanes();
        logic [9:0]  slot [mem_slots];
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] got;
        logic [2:0]  f3;
        logic [1:0]  lo;
        int          k;
        for (int i = 0; i < mem_slots; i++) begin
            r = rand_bits(10);
            slot[i] = r[9:0];
            data = rand_bits(32);
            do_store(synth_store_pkg::fnc_sw, mem_addr(slot[i], 2'b00), data);
            mem_model[slot[i]] = data;
        end
        for (int i = 0; i < mem_stores; i++) begin
            r = rand_bits(3);
            k = int'(r[2:0]);
            r = rand_bits(2);
            case (r[1:0])
                2'b00: f3 = synth_store_pkg::fnc_sb;
                2'b01: f3 = synth_store_pkg::fnc_sh;
                2'b10: f3 = synth_store_pkg::fnc_sw;
                default: f3 = 3'b111;   // no such width
            endcase
            r = rand_bits(2);
            lo = r[1:0];
            data = rand_bits(32);
            do_store(f3, mem_addr(slot[k], lo), data);
            mem_model[slot[k]] = merge_lanes(mem_model[slot[k]], f3, lo, data);
        end
        do_store(3'b011, mem_addr(slot[0], 2'b00), ~mem_model[slot[0]]);
        for (int i = 0; i < mem_slots; i++) begin
            read_word(slot[i], got);
            check(got, mem_model[slot[i]], "data memory word");
        end
    endtask

    task automatic test_voice_fcw();
        logic [31:0] data;
        for (int v = 0; v < synth_store_pkg::num_voices; v++) begin
            data = rand_bits(32);
            do_store(synth_store_pkg::fnc_sw, voice_addr(v, 12'h000), data);
            fcw_model[v] = data;
            check_voices("fcw after word store");
            for (int b = 0; b < 4; b++) begin
                data = rand_bits(8);
                do_store(synth_store_pkg::fnc_sb, voice_addr(v, 12'(b)), data);
                fcw_model[v] = merge_lanes(fcw_model[v], synth_store_pkg::fnc_sb, 2'(b), data);
                check_voices("fcw after byte store");
            end
        end
        // offsets and windows that match nothing
        do_store(synth_store_pkg::fnc_sw, voice_addr(1, 12'h00c), rand_bits(32));
        check_voices("fcw after unmatched offset");
        do_store(synth_store_pkg::fnc_sw, voice_addr(2, 12'h020), rand_bits(32));
        check_voices("fcw after store above voice words");
        do_store(synth_store_pkg::fnc_sw, 32'h8000_3000, rand_bits(32));
        check_voices("fcw after two-window store");
    endtask

    task automatic test_note_pulses();
        logic [11:0] off [3];
        logic [3:0]  hit;
        off = '{12'h004, 12'h008, 12'h010};
        for (int v = 0; v < synth_store_pkg::num_voices; v++) begin
            hit = 4'b0001 << v;
            for (int kind = 0; kind < 3; kind++) begin
                do_store(synth_store_pkg::fnc_sw, voice_addr(v, off[kind]), rand_bits(32));
                check(32'(cfg.note_start), kind == 0 ? 32'(hit) : 32'd0, "note start pulse");
                check(32'(cfg.note_release), kind == 1 ? 32'(hit) : 32'd0, "note release pulse");
                check(32'(cfg.voice_rst), kind == 2 ? 32'(hit) : 32'd0, "voice reset pulse");
                @(negedge clk);
                check_voices("pulse one cycle later");
            end
        end
    endtask

    task automatic test_shift_leds();
        logic [31:0] data;
        logic [4:0]  gs;
        logic [4:0]  ws [4];
        logic [7:0]  leds;
        data = rand_bits(32);
        do_store(synth_store_pkg::fnc_sw, 32'h8000_0104, data);
        gs = data[4:0];
        check(32'(cfg.global_shift), 32'(gs), "global shift");
        for (int w = 0; w < 4; w++) begin
            data = rand_bits(32);
            do_store(synth_store_pkg::fnc_sw, 32'h8000_0200 + 32'(4 * w), data);
            ws[w] = data[4:0];
            check(32'(cfg.wave_shift[w]), 32'(ws[w]), "wave shift");
        end
        data = rand_bits(32);
        do_store(synth_store_pkg::fnc_sw, 32'h8000_0030, data);
        leds = data[7:0];
        check(32'(cfg.leds), 32'(leds), "leds");
        // lane 1 does not carry these fields
        do_store(synth_store_pkg::fnc_sb, 32'h8000_0105, rand_bits(32));
        for (int w = 0; w < 4; w++) begin
            do_store(synth_store_pkg::fnc_sb, 32'h8000_0201 + 32'(4 * w), rand_bits(32));
        end
        do_store(synth_store_pkg::fnc_sb, 32'h8000_0031, rand_bits(32));
        check(32'(cfg.global_shift), 32'(gs), "global shift after lane 1 store");
        for (int w = 0; w < 4; w++) begin
            check(32'(cfg.wave_shift[w]), 32'(ws[w]), "wave shift after lane 1 store");
        end
        check(32'(cfg.leds), 32'(leds), "leds after lane 1 store");
    endtask

    task automatic test_counter();
        do_store(synth_store_pkg::fnc_sw, 32'h8000_0018, rand_bits(32));
        check(cfg.cycle_count, 32'd0, "cycle count after clear");
        for (int k = 1; k <= count_cycles; k++) begin
            @(negedge clk);
            check(cfg.cycle_count, 32'(k), "cycle count");
        end
        do_store(synth_store_pkg::fnc_sb, 32'h8000_001b, rand_bits(32));   // any lane clears
        check(cfg.cycle_count, 32'd0, "cycle count after byte clear");
    endtask

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        rd_addr = '0;
        lfsr_state = lfsr_seed;
        for (int v = 0; v < synth_store_pkg::num_voices; v++) begin
            fcw_model[v] = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_mem_lanes();
        test_voice_fcw();
        test_note_pulses();
        test_shift_leds();
        test_counter();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
synth_store_pkg.sv
store_align.sv
store_decode.sv
dmem.sv
synth_regs.sv
store_unit_top.sv
store_unit_assertions.sv
tb_store_unit.sv
